// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_extraction_core -f verilog.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"

// File: sim/tb_extraction_core.sv
`timescale 1ns/1ps
`include "parser_settings.svh"

module tb_extraction_core
    import parser_pkg::*;
();

    localparam int AW     = `PRS_ADDR_W;
    localparam int FW     = `PRS_FIELD_W;
    localparam int DW     = `PRS_DATA_W;
    localparam int NU     = `PRS_NUM_UNITS;
    localparam int DESC_W = `PRS_DESC_W;
    localparam int CW     = `PRS_CNT_W;
    localparam int DEPTH  = `PRS_BUF_WORDS;

    logic                clk;
    logic                rst_n_i;
    logic                flush_i;
    logic                header_valid_i;
    logic [AW-1:0]       start_addr_i;
    logic [NU*DESC_W-1:0] action_desc_i;
    logic [CW-1:0]       action_count_i;
    logic [FW-1:0]       lookup_value_i;
    logic                lookup_valid_i;
    logic [DW-1:0]       data_word_i;
    logic                data_valid_i;
    logic [AW-1:0]       finish_addr_o;
    logic                finish_valid_o;
    logic [FW-1:0]       dylen_o;
    logic                dylen_valid_o;
    logic [FW-1:0]       lookup_value_o;
    logic                lookup_valid_o;
    logic [NU*FW-1:0]    field_values_o;
    logic [NU-1:0]       field_valid_o;
    logic                head_finished_o;

    // packet under test and the action descriptors
    logic [DW-1:0]       pkt [DEPTH];
    field_desc_u         descs [NU];

    // reference model results
    logic [FW-1:0]       exp_field [NU];
    logic [FW-1:0]       saved_field [NU];
    logic [FW-1:0]       exp_dylen;
    logic                exp_dylen_vld;
    logic [FW-1:0]       exp_key;
    int                  exp_finish;
    int                  needed_words;

    int                  errors;
    int                  checks;

    extraction_core extraction_core_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .header_valid_i  (header_valid_i),
        .start_addr_i    (start_addr_i),
        .action_desc_i   (action_desc_i),
        .action_count_i  (action_count_i),
        .lookup_value_i  (lookup_value_i),
        .lookup_valid_i  (lookup_valid_i),
        .data_word_i     (data_word_i),
        .data_valid_i    (data_valid_i),
        .finish_addr_o   (finish_addr_o),
        .finish_valid_o  (finish_valid_o),
        .dylen_o         (dylen_o),
        .dylen_valid_o   (dylen_valid_o),
        .lookup_value_o  (lookup_value_o),
        .lookup_valid_o  (lookup_valid_o),
        .field_values_o  (field_values_o),
        .field_valid_o   (field_valid_o),
        .head_finished_o (head_finished_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [FW-1:0] exp,
                               input logic [FW-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic field_desc_u fixed_desc(input int len, input logic lk, input logic src);
        field_desc_u d;
        d = '0;
        d.fixed.flags.lookup    = lk;
        d.fixed.flags.dylen_src = src;
        d.fixed.len_bits        = 10'(len);
        return d;
    endfunction

    // length is base plus dylen shifted by shift
    function automatic field_desc_u dyn_desc(input int shift, input int base, input logic lk);
        field_desc_u d;
        d = '0;
        d.dyn.flags.dynamic = 1'b1;
        d.dyn.flags.lookup  = lk;
        d.dyn.unit_shift    = 4'(shift);
        d.dyn.base_bits     = 6'(base);
        return d;
    endfunction

    task automatic new_packet();
        for (int w = 0; w < DEPTH; w++) begin
            pkt[w] = {$urandom, $urandom};
        end
    endtask

    // address 0 is the msb of word 0
    function automatic logic pkt_bit(input int a);
        if (a < 0) begin
            return 1'b0;
        end
        return pkt[a / DW][DW - 1 - (a % DW)];
    endfunction

    // last bits of the field, last bit lands in the lsb
    function automatic logic [FW-1:0] slice_field(input int fin, input int len);
        logic [FW-1:0] v;
        v = '0;
        for (int i = 0; i < len && i < FW; i++) begin
            v[i] = pkt_bit(fin - 1 - i);
        end
        return v;
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    task automatic build_expected(input int start, input int count, input logic [FW-1:0] key);
        int            addr;
        int            len;
        logic [FW-1:0] dylen;
        addr          = start;
        dylen         = '0;
        exp_dylen     = '0;
        exp_dylen_vld = 1'b0;
        exp_key       = key;
        for (int k = 0; k < count; k++) begin
            if (descs[k].dyn.flags.dynamic) begin
                len = int'(descs[k].dyn.base_bits) + int'(dylen << descs[k].dyn.unit_shift);
            end else begin
                len = int'(descs[k].fixed.len_bits);
            end
            addr = addr + len;
            exp_field[k] = slice_field(addr, len);
            // later dynamic fields see this value
            if (descs[k].fixed.flags.dylen_src) begin
                dylen         = exp_field[k];
                exp_dylen     = exp_field[k];
                exp_dylen_vld = 1'b1;
            end
            if (descs[k].fixed.flags.lookup) begin
                // each field bit goes in at the bottom of the key
                for (int a = addr - len; a < addr; a++) begin
                    exp_key = {exp_key[FW-2:0], pkt_bit(a)};
                end
            end
        end
        exp_finish   = addr;
        // words up to the one that holds bit finish-1
        needed_words = (addr > 0) ? (addr - 1) / DW + 1 : 0;
    endtask

    // --------------------------------------------------
    // one action: load, stream words, wait, compare
    // --------------------------------------------------

    task automatic run_action(input string name, input int start, input int count,
                              input logic [FW-1:0] key, input logic key_vld,
                              input int max_gap);
        int gap;
        int waited;
        header_valid_i = 1'b1;
        start_addr_i   = AW'(start);
        action_count_i = CW'(count);
        lookup_value_i = key;
        lookup_valid_i = key_vld;
        for (int k = 0; k < NU; k++) begin
            action_desc_i[k*DESC_W +: DESC_W] = descs[k];
        end
        next_cycle();
        header_valid_i = 1'b0;
        build_expected(start, count, key);

        // whole packet goes in, gaps drawn per word
        for (int w = 0; w < DEPTH; w++) begin
            gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
            for (int g = 0; g <= gap; g++) begin
                if (w < needed_words) begin
                    check_value({name, " early finish"}, '0, FW'(head_finished_o));
                end
                if (g < gap) begin
                    next_cycle();
                end
            end
            data_word_i  = pkt[w];
            data_valid_i = 1'b1;
            next_cycle();
            data_valid_i = 1'b0;
        end

        waited = 0;
        while (head_finished_o !== 1'b1 && waited < 64) begin
            next_cycle();
            waited++;
        end
        if (head_finished_o !== 1'b1) begin
            errors++;
            $display("timeout: head_finished_o never rose in test %s", name);
        end

        for (int k = 0; k < NU; k++) begin
            if (k < count) begin
                check_value($sformatf("%s valid %0d", name, k), 1, FW'(field_valid_o[k]));
                check_value($sformatf("%s field %0d", name, k), exp_field[k],
                            field_values_o[k*FW +: FW]);
            end else begin
                // units past the count stay idle
                check_value($sformatf("%s valid %0d", name, k), 0, FW'(field_valid_o[k]));
            end
        end
        check_value({name, " finish addr"}, FW'(exp_finish), FW'(finish_addr_o));
        check_value({name, " finish valid"}, 1, FW'(finish_valid_o));
        check_value({name, " dylen valid"}, FW'(exp_dylen_vld), FW'(dylen_valid_o));
        check_value({name, " dylen"}, exp_dylen, dylen_o);
        check_value({name, " lookup valid"}, FW'(key_vld), FW'(lookup_valid_o));
        check_value({name, " lookup key"}, exp_key, lookup_value_o);
    endtask

    task automatic check_idle(input string name);
        check_value({name, " head finished"}, 0, FW'(head_finished_o));
        check_value({name, " field valid"}, 0, FW'(field_valid_o));
        check_value({name, " finish valid"}, 0, FW'(finish_valid_o));
        check_value({name, " dylen valid"}, 0, FW'(dylen_valid_o));
        check_value({name, " lookup valid"}, 0, FW'(lookup_valid_o));
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    // second field crosses from word 0 into word 1
    task automatic test_fixed_fields();
        new_packet();
        descs[0] = fixed_desc(20, 1'b0, 1'b0);
        descs[1] = fixed_desc(16, 1'b0, 1'b0);
        descs[2] = fixed_desc(32, 1'b0, 1'b0);
        descs[3] = fixed_desc(7, 1'b0, 1'b0);
        run_action("fixed", 40, 4, 32'h1234_5678, 1'b0, 0);
        check_value("fixed length sum", FW'(40 + 20 + 16 + 32 + 7), FW'(finish_addr_o));
    endtask

    task automatic test_dynamic_length();
        new_packet();
        descs[0] = fixed_desc(4, 1'b0, 1'b1);
        descs[1] = dyn_desc(3, 4, 1'b0);
        descs[2] = fixed_desc(10, 1'b0, 1'b0);
        descs[3] = dyn_desc(1, 2, 1'b0);
        run_action("dynamic", 8, 4, '0, 1'b0, 0);
    endtask

    task automatic test_lookup_key();
        new_packet();
        descs[0] = fixed_desc(8, 1'b1, 1'b0);
        descs[1] = fixed_desc(5, 1'b0, 1'b0);
        descs[2] = fixed_desc(6, 1'b1, 1'b0);
        descs[3] = fixed_desc(3, 1'b1, 1'b0);
        run_action("lookup", 17, 4, 32'h0000_00a5, 1'b1, 0);
        run_action("lookup invalid", 17, 4, 32'h0000_00a5, 1'b0, 0);
    endtask

    // units 2 and 3 carry flags that must have no effect
    task automatic test_partial_count();
        new_packet();
        descs[0] = fixed_desc(12, 1'b1, 1'b1);
        descs[1] = fixed_desc(9, 1'b0, 1'b0);
        descs[2] = fixed_desc(30, 1'b1, 1'b0);
        descs[3] = dyn_desc(2, 5, 1'b1);
        run_action("partial", 70, 2, 32'h0000_0003, 1'b1, 0);
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        check_idle("flush");
    endtask

    // same action with and without gaps between words
    task automatic test_word_gaps();
        new_packet();
        descs[0] = fixed_desc(30, 1'b1, 1'b0);
        descs[1] = fixed_desc(25, 1'b0, 1'b0);
        descs[2] = fixed_desc(20, 1'b1, 1'b0);
        descs[3] = fixed_desc(18, 1'b0, 1'b0);
        run_action("no gaps", 300, 4, 32'h0000_0001, 1'b1, 0);
        for (int k = 0; k < NU; k++) begin
            saved_field[k] = field_values_o[k*FW +: FW];
        end
        run_action("gaps", 300, 4, 32'h0000_0001, 1'b1, 5);
        for (int k = 0; k < NU; k++) begin
            check_value($sformatf("gaps same field %0d", k), saved_field[k],
                        field_values_o[k*FW +: FW]);
        end
    endtask

    initial begin
        errors         = 0;
        checks         = 0;
        void'($urandom(32'hd555_6ab0));
        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        header_valid_i = 1'b0;
        start_addr_i   = '0;
        action_desc_i  = '0;
        action_count_i = '0;
        lookup_value_i = '0;
        lookup_valid_i = 1'b0;
        data_word_i    = '0;
        data_valid_i   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        next_cycle();
        check_idle("reset");

        test_fixed_fields();
        test_dynamic_length();
        test_lookup_key();
        test_partial_count();
        test_word_gaps();

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: source/extraction_core.sv
`timescale 1ns/1ps
`include "parser_settings.svh"

module extraction_core
    import parser_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    flush_i,
    input  logic                                    header_valid_i,
    input  logic [`PRS_ADDR_W-1:0]                  start_addr_i,
    input  logic [`PRS_NUM_UNITS*`PRS_DESC_W-1:0]   action_desc_i,
    input  logic [`PRS_CNT_W-1:0]                   action_count_i,
    input  logic [`PRS_FIELD_W-1:0]                 lookup_value_i,
    input  logic                                    lookup_valid_i,
    input  logic [`PRS_DATA_W-1:0]                  data_word_i,
    input  logic                                    data_valid_i,
    output logic [`PRS_ADDR_W-1:0]                  finish_addr_o,
    output logic                                    finish_valid_o,
    output logic [`PRS_FIELD_W-1:0]                 dylen_o,
    output logic                                    dylen_valid_o,
    output logic [`PRS_FIELD_W-1:0]                 lookup_value_o,
    output logic                                    lookup_valid_o,
    output logic [`PRS_NUM_UNITS*`PRS_FIELD_W-1:0]  field_values_o,
    output logic [`PRS_NUM_UNITS-1:0]               field_valid_o,
    output logic                                    head_finished_o
);

    localparam int AW     = `PRS_ADDR_W;
    localparam int FW     = `PRS_FIELD_W;
    localparam int NU     = `PRS_NUM_UNITS;
    localparam int CW     = `PRS_CNT_W;
    localparam int WCNT_W = $clog2(`PRS_BUF_WORDS + 1);

    // action registers
    logic                   act_valid_q;
    logic [AW-1:0]          start_q;
    field_desc_u [NU-1:0]   desc_q;
    logic [CW-1:0]          count_q;
    logic [FW-1:0]          lookup_q;
    logic                   lookup_valid_q;
    logic                   head_fin_q;
    logic                   clear;

    // chain links, slot k feeds unit k
    logic [(NU+1)*AW-1:0]   addr_chain;
    logic [NU:0]            addr_vld;
    logic [(NU+1)*FW-1:0]   dylen_chain;
    logic [NU:0]            dylen_vld;
    logic [(NU+1)*FW-1:0]   lk_chain;
    logic [NU:0]            lk_vld;

    logic [NU-1:0]          unit_active;
    logic [NU-1:0]          unit_done;
    logic [NU*AW-1:0]       win_addr;
    logic [NU*FW-1:0]       win_data;
    logic [WCNT_W-1:0]      words;

    // --------------------------------------------------
    // action capture
    // --------------------------------------------------

    // a new header or a flush restarts buffer and units
    assign clear = header_valid_i || flush_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            act_valid_q    <= 1'b0;
            count_q        <= '0;
            lookup_valid_q <= 1'b0;
        end else if (header_valid_i) begin
            act_valid_q    <= 1'b1;
            count_q        <= action_count_i;
            lookup_valid_q <= lookup_valid_i;
        end else if (flush_i) begin
            act_valid_q    <= 1'b0;
            lookup_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (header_valid_i) begin
            start_q  <= start_addr_i;
            desc_q   <= action_desc_i;
            lookup_q <= lookup_value_i;
        end
    end

    // units below the action count take part
    always_comb begin
        for (int k = 0; k < NU; k++) begin
            unit_active[k] = (count_q > CW'(k));
        end
    end

    // --------------------------------------------------
    // chain head and tail
    // --------------------------------------------------

    assign addr_chain[0 +: AW] = start_q;
    assign addr_vld[0]         = act_valid_q;
    // nothing ahead of unit 0 can publish a dylen
    assign dylen_chain[0 +: FW] = '0;
    assign dylen_vld[0]         = 1'b0;
    assign lk_chain[0 +: FW]    = lookup_q;
    assign lk_vld[0]            = lookup_valid_q;

    assign finish_addr_o  = addr_chain[NU*AW +: AW];
    assign finish_valid_o = addr_vld[NU];
    assign dylen_o        = dylen_chain[NU*FW +: FW];
    assign dylen_valid_o  = dylen_vld[NU];
    assign lookup_value_o = lk_chain[NU*FW +: FW];
    assign lookup_valid_o = lk_vld[NU];

    // --------------------------------------------------
    // buffer and units
    // --------------------------------------------------

    header_buffer #(
        .WCNT_W         (WCNT_W)
    ) header_buffer_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .clear_i        (clear),
        .word_valid_i   (data_valid_i),
        .word_i         (data_word_i),
        .words_o        (words),
        .window_addr_i  (win_addr),
        .window_o       (win_data)
    );

    for (genvar k = 0; k < NU; k++) begin : g_unit
        extraction_unit #(
            .WCNT_W         (WCNT_W)
        ) unit_i (
            .clk            (clk),
            .rst_n_i        (rst_n_i),
            .clear_i        (clear),
            .active_i       (unit_active[k]),
            .desc_i         (desc_q[k]),
            .start_addr_i   (addr_chain[k*AW +: AW]),
            .start_valid_i  (addr_vld[k]),
            .dylen_i        (dylen_chain[k*FW +: FW]),
            .dylen_valid_i  (dylen_vld[k]),
            .lookup_i       (lk_chain[k*FW +: FW]),
            .lookup_valid_i (lk_vld[k]),
            .words_i        (words),
            .window_i       (win_data[k*FW +: FW]),
            .finish_addr_o  (addr_chain[(k+1)*AW +: AW]),
            .finish_valid_o (addr_vld[k+1]),
            .window_addr_o  (win_addr[k*AW +: AW]),
            .dylen_o        (dylen_chain[(k+1)*FW +: FW]),
            .dylen_valid_o  (dylen_vld[k+1]),
            .lookup_o       (lk_chain[(k+1)*FW +: FW]),
            .lookup_valid_o (lk_vld[k+1]),
            .field_o        (field_values_o[k*FW +: FW]),
            .field_valid_o  (field_valid_o[k]),
            .done_o         (unit_done[k])
        );
    end

    // --------------------------------------------------
    // completion
    // --------------------------------------------------

    // sticky until the next header or flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_fin_q <= 1'b0;
        end else if (clear) begin
            head_fin_q <= 1'b0;
        end else if (act_valid_q && (&unit_done)) begin
            head_fin_q <= 1'b1;
        end
    end

    assign head_finished_o = head_fin_q;

    // header load and packet words share no cycle
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(header_valid_i && data_valid_i));

endmodule

// File: source/extraction_unit.sv
`timescale 1ns/1ps
`include "parser_settings.svh"

module extraction_unit
    import parser_pkg::*;
#(
    parameter int WCNT_W = $clog2(`PRS_BUF_WORDS + 1)
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    clear_i,
    input  logic                    active_i,
    input  field_desc_u             desc_i,
    input  logic [`PRS_ADDR_W-1:0]  start_addr_i,
    input  logic                    start_valid_i,
    input  logic [`PRS_FIELD_W-1:0] dylen_i,
    input  logic                    dylen_valid_i,
    input  logic [`PRS_FIELD_W-1:0] lookup_i,
    input  logic                    lookup_valid_i,
    input  logic [WCNT_W-1:0]       words_i,
    input  logic [`PRS_FIELD_W-1:0] window_i,
    output logic [`PRS_ADDR_W-1:0]  finish_addr_o,
    output logic                    finish_valid_o,
    output logic [`PRS_ADDR_W-1:0]  window_addr_o,
    output logic [`PRS_FIELD_W-1:0] dylen_o,
    output logic                    dylen_valid_o,
    output logic [`PRS_FIELD_W-1:0] lookup_o,
    output logic                    lookup_valid_o,
    output logic [`PRS_FIELD_W-1:0] field_o,
    output logic                    field_valid_o,
    output logic                    done_o
);

    localparam int AW      = `PRS_ADDR_W;
    localparam int FW      = `PRS_FIELD_W;
    localparam int DW      = `PRS_DATA_W;
    localparam int WORD_SH = $clog2(DW);

    desc_flags_t   flags;
    logic [FW-1:0] dyn_len;
    logic [AW-1:0] len_d;
    logic          can_finish;
    logic          fin_load;
    logic [AW-1:0] finish_q;
    logic [AW-1:0] len_q;
    logic          fin_valid_q;
    logic [AW:0]   need_words;
    logic          data_ready;
    logic [FW-1:0] field_mask;
    logic [FW-1:0] field_q;
    logic          fld_valid_q;

    // --------------------------------------------------
    // descriptor decode
    // --------------------------------------------------

    // flags sit in the same bits of both views
    assign flags = desc_i.fixed.flags;

    // dynamic length scales the upstream dylen by a power of two
    assign dyn_len = (dylen_i << desc_i.dyn.unit_shift) + FW'(desc_i.dyn.base_bits);
    assign len_d   = flags.dynamic ? dyn_len[AW-1:0] : AW'(desc_i.fixed.len_bits);

    // a dynamic field also waits on its dylen source
    assign can_finish = active_i && start_valid_i && (!flags.dynamic || dylen_valid_i);
    assign fin_load   = can_finish && !fin_valid_q;

    // --------------------------------------------------
    // finish address stage
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fin_valid_q <= 1'b0;
        end else if (clear_i) begin
            fin_valid_q <= 1'b0;
        end else if (fin_load) begin
            fin_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fin_load) begin
            finish_q <= start_addr_i + len_d;
            len_q    <= len_d;
        end
    end

    // --------------------------------------------------
    // field capture stage
    // --------------------------------------------------

    // words needed so the last field bit is in the buffer
    assign need_words = ({1'b0, finish_q} + (AW + 1)'(DW - 1)) >> WORD_SH;
    assign data_ready = fin_valid_q && (need_words <= (AW + 1)'(words_i));

    // keep only the field bits of the window
    assign field_mask = (len_q >= AW'(FW)) ? '1 : ((FW'(1) << len_q) - FW'(1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fld_valid_q <= 1'b0;
        end else if (clear_i) begin
            fld_valid_q <= 1'b0;
        end else if (data_ready && !fld_valid_q) begin
            fld_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ready && !fld_valid_q) begin
            field_q <= window_i & field_mask;
        end
    end

    // --------------------------------------------------
    // chain outputs
    // --------------------------------------------------

    // buffer window always follows the registered finish
    assign window_addr_o = finish_q;

    // inactive unit is a straight pass of the chain
    assign finish_addr_o  = active_i ? finish_q : start_addr_i;
    assign finish_valid_o = active_i ? fin_valid_q : start_valid_i;

    // dylen source publishes its own field downstream
    assign dylen_o       = (active_i && flags.dylen_src) ? field_q : dylen_i;
    assign dylen_valid_o = (active_i && flags.dylen_src) ? fld_valid_q : dylen_valid_i;

    // append the field below the incoming key
    always_comb begin
        if (active_i && flags.lookup) begin
            lookup_o       = (lookup_i << len_q) | field_q;
            lookup_valid_o = lookup_valid_i && fld_valid_q;
        end else begin
            lookup_o       = lookup_i;
            lookup_valid_o = lookup_valid_i;
        end
    end

    assign field_o       = field_q;
    assign field_valid_o = active_i && fld_valid_q;
    assign done_o        = !active_i || fld_valid_q;

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    // field only rises after its finish address was already resolved
    assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(field_valid_o) |-> $past(finish_valid_o));

    // upstream dylen must be in place whenever a dynamic finish is held
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (active_i && flags.dynamic && fin_valid_q) |-> dylen_valid_i);

endmodule

// File: source/header_buffer.sv
`timescale 1ns/1ps
`include "parser_settings.svh"

module header_buffer #(
    parameter int WCNT_W = $clog2(`PRS_BUF_WORDS + 1)
) (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    clear_i,
    input  logic                                    word_valid_i,
    input  logic [`PRS_DATA_W-1:0]                  word_i,
    output logic [WCNT_W-1:0]                       words_o,
    input  logic [`PRS_NUM_UNITS*`PRS_ADDR_W-1:0]   window_addr_i,
    output logic [`PRS_NUM_UNITS*`PRS_FIELD_W-1:0]  window_o
);

    localparam int DW     = `PRS_DATA_W;
    localparam int AW     = `PRS_ADDR_W;
    localparam int FW     = `PRS_FIELD_W;
    localparam int NU     = `PRS_NUM_UNITS;
    localparam int DEPTH  = `PRS_BUF_WORDS;
    localparam int WIDX_W = $clog2(DEPTH);
    localparam int HDR_W  = DW * DEPTH;

    logic [DW-1:0]       mem_q [DEPTH];
    logic [WCNT_W-1:0]   count_q;
    logic                full;
    logic                wr_en;
    logic [HDR_W-1:0]    hdr_flat;
    logic [HDR_W+FW-1:0] hdr_ext;

    // --------------------------------------------------
    // word storage
    // --------------------------------------------------

    assign full    = (count_q == WCNT_W'(DEPTH));
    // words past the last slot are dropped
    assign wr_en   = word_valid_i && !full && !clear_i;
    assign words_o = count_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (wr_en) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[count_q[WIDX_W-1:0]] <= word_i;
        end
    end

    // --------------------------------------------------
    // window extraction
    // --------------------------------------------------

    // word 0 lands in the top bits so address 0 is the msb
    always_comb begin
        for (int w = 0; w < DEPTH; w++) begin
            hdr_flat[HDR_W-1-w*DW -: DW] = mem_q[w];
        end
    end

    // zero pad above the msb covers addresses below 0
    assign hdr_ext = {{FW{1'b0}}, hdr_flat};

    for (genvar u = 0; u < NU; u++) begin : g_win
        logic [AW-1:0]       fin;
        logic [AW-1:0]       lsb_idx;
        logic [HDR_W+FW-1:0] shifted;

        assign fin     = window_addr_i[u*AW +: AW];
        // bit of address fin-1 sits at index HDR_W-fin
        assign lsb_idx = AW'(HDR_W) - fin;
        assign shifted = hdr_ext >> lsb_idx;
        // out of range finish gives an empty window
        assign window_o[u*FW +: FW] = (fin > AW'(HDR_W)) ? '0 : shifted[FW-1:0];
    end

    // upstream never sends more than a full header
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (word_valid_i && !clear_i) |-> !full);

endmodule

// File: source/parser_pkg.sv
package parser_pkg;

    // --------------------------------------------------
    // descriptor flags
    // --------------------------------------------------

    // top six bits of every descriptor, same place in both views
    typedef struct packed {
        // low ten bits hold shift and base
        logic       dynamic;
        // field gets appended to the lookup key
        logic       lookup;
        // field value feeds later dynamic fields
        logic       dylen_src;
        logic [2:0] rsvd;
    } desc_flags_t;

    // --------------------------------------------------
    // the two views of one descriptor word
    // --------------------------------------------------

    // fixed form carries the length directly
    typedef struct packed {
        desc_flags_t flags;
        logic [9:0]  len_bits;
    } desc_fixed_t;

    // dynamic form: base_bits + (dylen << unit_shift)
    typedef struct packed {
        desc_flags_t flags;
        logic [3:0]  unit_shift;
        logic [5:0]  base_bits;
    } desc_dyn_t;

    typedef union packed {
        desc_fixed_t fixed;
        desc_dyn_t   dyn;
    } field_desc_u;

endpackage

// File: source/parser_settings.svh
`ifndef PARSER_SETTINGS_SVH
`define PARSER_SETTINGS_SVH

// --------------------------------------------------
// datapath widths
// --------------------------------------------------

// packet word width in bits
`define PRS_DATA_W      64

// header buffer depth in words
`define PRS_BUF_WORDS   8

// bit address into the buffered header
`define PRS_ADDR_W      16

// widest extracted field and lookup key width
`define PRS_FIELD_W     32

// --------------------------------------------------
// action layout
// --------------------------------------------------

// extraction units in the chain
`define PRS_NUM_UNITS   4

// one field descriptor
`define PRS_DESC_W      16

// active unit count, 0 up to PRS_NUM_UNITS
`define PRS_CNT_W       3

`endif

// File: verilog.f
+incdir+source
source/parser_pkg.sv
source/header_buffer.sv
source/extraction_unit.sv
source/extraction_core.sv
sim/tb_extraction_core.sv
